// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns
TOP      := evrSrocTb
FILELIST := filelist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: filelist.f
+incdir+verification
hw/evrSrocPkg.sv
hw/srocGenerator.sv
hw/markerWatchdog.sv
hw/evrSroc.sv
verification/evrSrocTb.sv

// File: hw/evrSroc.sv
// ****************************************
// EVR monitor and SROC top level
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module evrSroc
    import evrSrocPkg::*;
(
    input  wire         evrClk,
    input  wire         rst,
    input  evrMarkers_t markers,
    output logic        sroc,
    output evrStatus_t  status
);

    logic srocSynced;
    logic heartbeatValid;
    logic ppsValid;

    // ****************************************
    // Orbit clock
    // ****************************************

    srocGenerator srocGen_i (
        .evrClk     (evrClk),
        .rst        (rst),
        .heartbeat  (markers.heartbeat),
        .sroc       (sroc),
        .srocSynced (srocSynced)
    );

    // ****************************************
    // Marker watchdogs
    // ****************************************

    markerWatchdog hbWatchdog_i (
        .evrClk  (evrClk),
        .rst     (rst),
        .marker  (markers.heartbeat),
        .isValid (heartbeatValid)
    );

    markerWatchdog ppsWatchdog_i (
        .evrClk  (evrClk),
        .rst     (rst),
        .marker  (markers.pulsePerSecond),
        .isValid (ppsValid)
    );

    // Status word, all bits registered in the blocks.
    assign status = '{
        srocSynced:     srocSynced,
        heartbeatValid: heartbeatValid,
        ppsValid:       ppsValid
    };

endmodule

`default_nettype wire

// File: hw/evrSrocPkg.sv
// ****************************************
// EVR orbit clock shared definitions
// ****************************************
`default_nettype none

package evrSrocPkg;

    // ****************************************
    // Storage ring orbit clock divider
    // ****************************************

    // Event clocks per SROC period.
    localparam int srocDivider = 7;

    // Low half is the longer one when the divider is odd.
    localparam int srocReloadLo = ((srocDivider + 1) / 2) - 1;
    localparam int srocReloadHi = (srocDivider / 2) - 1;

    localparam int srocCountWidth = $clog2(srocReloadLo + 1);

    // ****************************************
    // Marker watchdog window
    // ****************************************

    // Nominal marker spacing, 30 SROC periods.
    localparam int markerNominalCycles = 30 * srocDivider;

    localparam int markerLowerLimit = (markerNominalCycles * 9) / 10;   // -10 %.
    localparam int markerUpperLimit = (markerNominalCycles * 11) / 10;  // +10 %.

    // Counter saturates at the upper limit.
    localparam int watchdogWidth = $clog2(markerUpperLimit + 1);

    // ****************************************
    // Marker and status words
    // ****************************************

    typedef struct packed {
        logic heartbeat;        // Heartbeat marker level.
        logic pulsePerSecond;   // PPS marker level.
    } evrMarkers_t;

    typedef struct packed {
        logic srocSynced;       // Heartbeat landed on a period boundary.
        logic heartbeatValid;   // Heartbeat interval within window.
        logic ppsValid;         // PPS interval within window.
    } evrStatus_t;

endpackage

`default_nettype wire

// File: hw/markerWatchdog.sv
// ****************************************
// Event marker interval watchdog
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module markerWatchdog
    import evrSrocPkg::*;
(
    input  wire  evrClk,
    input  wire  rst,
    input  wire  marker,
    output logic isValid
);

    logic                     markerPrev;
    logic                     markerEdge;
    logic [watchdogWidth-1:0] watchdogCount;
    logic                     belowLimit;
    logic                     inWindow;

    // ****************************************
    // Edge detection
    // ****************************************

    always_ff @(posedge evrClk) begin
        if (rst) begin
            markerPrev <= 1'b0;
        end else begin
            markerPrev <= marker;
        end
    end

    assign markerEdge = marker && !markerPrev;

    // ****************************************
    // Interval counter
    // ****************************************

    assign belowLimit = watchdogCount < watchdogWidth'(markerUpperLimit);

    // Count holds interval minus one at the next edge.
    assign inWindow = (watchdogCount > watchdogWidth'(markerLowerLimit)) && belowLimit;

    always_ff @(posedge evrClk) begin
        if (rst) begin
            // Start saturated so the first edge never qualifies.
            watchdogCount <= watchdogWidth'(markerUpperLimit);
        end else if (markerEdge) begin
            watchdogCount <= '0;
        end else if (belowLimit) begin
            watchdogCount <= watchdogCount + 1'b1;
        end
    end

    // ****************************************
    // Validity flag
    // ****************************************

    always_ff @(posedge evrClk) begin
        if (rst) begin
            isValid <= 1'b0;
        end else if (markerEdge) begin
            isValid <= inWindow;      // Judge the interval just ended.
        end else if (!belowLimit) begin
            isValid <= 1'b0;          // Marker overdue.
        end
    end

endmodule

`default_nettype wire

// File: hw/srocGenerator.sv
// ****************************************
// SROC generator
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module srocGenerator
    import evrSrocPkg::*;
(
    input  wire  evrClk,
    input  wire  rst,
    input  wire  heartbeat,
    output logic sroc,
    output logic srocSynced
);

    logic                      heartbeatPrev;
    logic                      heartbeatEdge;
    logic [srocCountWidth-1:0] srocCount;
    logic                      atBoundary;

    // ****************************************
    // Heartbeat edge detection
    // ****************************************

    always_ff @(posedge evrClk) begin
        if (rst) begin
            heartbeatPrev <= 1'b0;
        end else begin
            heartbeatPrev <= heartbeat;
        end
    end

    assign heartbeatEdge = heartbeat && !heartbeatPrev;   // First high cycle.

    // Last cycle of the high half, so the next cycle starts a new period.
    assign atBoundary = sroc && (srocCount == '0);

    // ****************************************
    // Divider
    // ****************************************

    always_ff @(posedge evrClk) begin
        if (rst) begin
            sroc      <= 1'b0;
            srocCount <= srocCountWidth'(srocReloadLo);   // Free-run from reset.
        end else if (heartbeatEdge) begin
            sroc      <= 1'b0;                            // Force phase zero.
            srocCount <= srocCountWidth'(srocReloadLo);
        end else if (srocCount == '0) begin
            sroc <= !sroc;
            if (sroc) begin
                srocCount <= srocCountWidth'(srocReloadLo);   // Going low.
            end else begin
                srocCount <= srocCountWidth'(srocReloadHi);   // Going high.
            end
        end else begin
            srocCount <= srocCount - 1'b1;
        end
    end

    // ****************************************
    // Sync check
    // ****************************************

    // Updated only on a heartbeat; holds between heartbeats.
    always_ff @(posedge evrClk) begin
        if (rst) begin
            srocSynced <= 1'b0;
        end else if (heartbeatEdge) begin
            srocSynced <= atBoundary;
        end
    end

endmodule

`default_nettype wire

// File: verification/evrSrocTests.svh
// ****************************************
// EVR SROC directed tests
// ****************************************
`ifndef EVR_SROC_TESTS_SVH
`define EVR_SROC_TESTS_SVH

task automatic resetStateTest();
    beginTest("reset state");
    checkBit("srocSynced", 1'b0, status.srocSynced);
    checkBit("heartbeatValid", 1'b0, status.heartbeatValid);
    checkBit("ppsValid", 1'b0, status.ppsValid);
    // Three free-running periods from reset release.
    while (cycleCount - lastPhaseZero < 3 * srocDivider) begin
        checkBit($sformatf("sroc %0d cycles after reset", cycleCount - lastPhaseZero),
                 expectedSroc(cycleCount - lastPhaseZero), sroc);
        waitCycles(1);
    end
    endTest();
endtask

task automatic phaseResetTest();
    int   delay;
    logic expSynced;
    beginTest("phase reset");
    delay = 3 + int'({$random(seed)} % 10);
    waitCycles(delay);
    markers.heartbeat = 1'b1;
    lastHbIndex       = cycleCount + 1;
    expSynced         = syncExpected(lastHbIndex - lastPhaseZero);
    lastPhaseZero     = lastHbIndex;
    waitCycles(1);
    checkBit("srocSynced", expSynced, status.srocSynced);
    checkBit("heartbeatValid", 1'b0, status.heartbeatValid);   // First heartbeat since reset.
    checkBit("ppsValid", 1'b0, status.ppsValid);
    while (cycleCount - lastPhaseZero < 2 * srocDivider) begin
        checkBit($sformatf("sroc %0d cycles after edge", cycleCount - lastPhaseZero),
                 expectedSroc(cycleCount - lastPhaseZero), sroc);
        if (cycleCount - lastPhaseZero == 1) begin
            markers.heartbeat = 1'b0;
        end
        waitCycles(1);
    end
    endTest();
endtask

task automatic syncDetectTest();
    int         gaps[4];
    evrStatus_t seen;
    beginTest("sync detection");
    gaps = '{210, 210, 213, 210};
    foreach (gaps[i]) begin
        idleForInterval(gaps[i]);
        pulseMarkers(1'b1, 1'b0, seen);
        checkBit($sformatf("srocSynced after %0d", gaps[i]),
                 syncExpected(gaps[i]), seen.srocSynced);
        checkBit($sformatf("heartbeatValid after %0d", gaps[i]),
                 windowExpected(gaps[i]), seen.heartbeatValid);
    end
    endTest();
endtask

task automatic heartbeatWindowTest();
    int         gaps[14];
    evrStatus_t seen;
    beginTest("heartbeat window");
    gaps[0] = 190;
    gaps[1] = 191;
    gaps[2] = 231;
    gaps[3] = 232;
    for (int i = 4; i < 14; i++) begin
        gaps[i] = 150 + int'({$random(seed)} % 111);   // 150 to 260.
    end
    foreach (gaps[i]) begin
        idleForInterval(gaps[i]);
        pulseMarkers(1'b1, 1'b0, seen);
        checkBit($sformatf("heartbeatValid after %0d", gaps[i]),
                 windowExpected(gaps[i]), seen.heartbeatValid);
        checkBit($sformatf("srocSynced after %0d", gaps[i]),
                 syncExpected(gaps[i]), seen.srocSynced);
    end
    endTest();
endtask

task automatic watchdogTimeoutTest();
    int         lastPps;
    evrStatus_t seen;
    beginTest("watchdog timeout");
    idleForInterval(nominalGap);
    pulseMarkers(1'b1, 1'b1, seen);
    checkBit("heartbeatValid at first PPS", 1'b1, seen.heartbeatValid);
    checkBit("ppsValid at first PPS", 1'b0, seen.ppsValid);
    idleForInterval(nominalGap);
    pulseMarkers(1'b1, 1'b1, seen);
    checkBit("heartbeatValid at second PPS", 1'b1, seen.heartbeatValid);
    checkBit("ppsValid at second PPS", 1'b1, seen.ppsValid);
    lastPps = lastHbIndex;
    // PPS stops here, heartbeat keeps its nominal spacing.
    while (cycleCount - lastPps <= overdueCycles + 8) begin
        checkBit($sformatf("ppsValid %0d cycles after PPS", cycleCount - lastPps),
                 (cycleCount - lastPps) < overdueCycles, status.ppsValid);
        checkBit($sformatf("heartbeatValid %0d cycles after PPS", cycleCount - lastPps),
                 1'b1, status.heartbeatValid);
        if (cycleCount + 1 - lastHbIndex == nominalGap) begin
            markers.heartbeat = 1'b1;
            lastHbIndex       = cycleCount + 1;
            lastPhaseZero     = lastHbIndex;
        end else if (cycleCount - lastHbIndex == 1) begin
            markers.heartbeat = 1'b0;
        end
        waitCycles(1);
    end
    endTest();
endtask

task automatic midRunResetTest();
    logic       expSynced;
    evrStatus_t seen;
    beginTest("mid-run reset");
    // Raise every status bit so the reset has something to clear.
    pulseMarkers(1'b1, 1'b1, seen);
    idleForInterval(nominalGap);
    pulseMarkers(1'b1, 1'b1, seen);
    checkBit("srocSynced before reset", syncExpected(nominalGap), seen.srocSynced);
    checkBit("heartbeatValid before reset", windowExpected(nominalGap), seen.heartbeatValid);
    checkBit("ppsValid before reset", windowExpected(nominalGap), seen.ppsValid);
    applyReset(resetCycles);
    checkBit("srocSynced after reset", 1'b0, status.srocSynced);
    checkBit("heartbeatValid after reset", 1'b0, status.heartbeatValid);
    checkBit("ppsValid after reset", 1'b0, status.ppsValid);
    checkBit("sroc after reset", 1'b0, sroc);
    expSynced = syncExpected(cycleCount + 1 - lastPhaseZero);
    pulseMarkers(1'b1, 1'b1, seen);
    checkBit("srocSynced at first edge", expSynced, seen.srocSynced);
    checkBit("heartbeatValid at first edge", 1'b0, seen.heartbeatValid);
    checkBit("ppsValid at first edge", 1'b0, seen.ppsValid);
    idleForInterval(nominalGap);
    pulseMarkers(1'b1, 1'b1, seen);
    checkBit("srocSynced at second edge", syncExpected(nominalGap), seen.srocSynced);
    checkBit("heartbeatValid at second edge", 1'b1, seen.heartbeatValid);
    checkBit("ppsValid at second edge", 1'b1, seen.ppsValid);
    endTest();
endtask

`endif

// File: verification/evrSrocTb.sv
// ****************************************
// EVR SROC monitor testbench
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module evrSrocTb
    import evrSrocPkg::*;
();

    localparam int timeoutCycles    = 6000;  // Worst case of all tests is about 5500 cycles.
    localparam int resetCycles      = 8;
    localparam int nominalGap       = 210;   // 30 SROC periods.
    localparam int srocLowCycles    = 4;     // Low half right after phase zero.
    localparam int minValidInterval = 191;
    localparam int maxValidInterval = 231;
    localparam int overdueCycles    = 232;   // Valid drops this long after the last edge.

    bit          evrClk;
    logic        rst;
    evrMarkers_t markers;
    logic        sroc;
    evrStatus_t  status;

    int     cycleCount;      // Posedges since time zero.
    int     lastPhaseZero;   // Posedge index of the last reset or heartbeat edge.
    int     lastHbIndex;     // Posedge index of the last heartbeat edge.
    integer seed;
    string  currentTest;
    int     testsRun;
    int     totalChecks;
    int     totalErrors;
    int     testChecks;
    int     testErrors;

    evrSroc dut_i (
        .evrClk  (evrClk),
        .rst     (rst),
        .markers (markers),
        .sroc    (sroc),
        .status  (status)
    );

    initial begin
        forever begin
            #2 evrClk = ~evrClk;
        end
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge evrClk);
            cycleCount++;
        end
    end

    // ****************************************
    // Drivers and reference rules
    // ****************************************

    task automatic waitCycles(input int n);
        repeat (n) @(negedge evrClk);
    endtask

    task automatic applyReset(input int cycles);
        rst     = 1'b1;
        markers = '0;
        waitCycles(cycles);
        rst           = 1'b0;
        lastPhaseZero = cycleCount;   // Last posedge with reset high.
    endtask

    // Two-cycle pulse; status is taken one cycle after the edge.
    task automatic pulseMarkers(input logic hb, input logic pps, output evrStatus_t seenStatus);
        markers.heartbeat      = hb;
        markers.pulsePerSecond = pps;
        if (hb) begin
            lastHbIndex   = cycleCount + 1;
            lastPhaseZero = lastHbIndex;
        end
        waitCycles(1);
        seenStatus = status;
        waitCycles(1);
        markers = '0;
    endtask

    // Returns just before the posedge that makes the next edge gap cycles after the last one.
    task automatic idleForInterval(input int gap);
        waitCycles(lastHbIndex + gap - 1 - cycleCount);
    endtask

    function automatic logic expectedSroc(input int cyclesSincePhaseZero);
        return (cyclesSincePhaseZero % srocDivider) >= srocLowCycles;
    endfunction

    function automatic logic syncExpected(input int interval);
        return (interval % srocDivider) == 0;
    endfunction

    function automatic logic windowExpected(input int interval);
        return (interval >= minValidInterval) && (interval <= maxValidInterval);
    endfunction

    // ****************************************
    // Checking and reporting
    // ****************************************

    task automatic checkBit(input string what, input logic expected, input logic actual);
        testChecks++;
        assert (actual === expected) else begin
            $display("Fail %s, %s: expected %0b, actual %0b",
                     currentTest, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic beginTest(input string name);
        currentTest = name;
        testChecks  = 0;
        testErrors  = 0;
        testsRun++;
    endtask

    task automatic endTest();
        totalChecks += testChecks;
        totalErrors += testErrors;
        $display("Test %s finished: %0d checks, %0d errors", currentTest, testChecks, testErrors);
    endtask

    `include "evrSrocTests.svh"

    initial begin
        rst           = 1'b1;
        markers       = '0;
        seed          = 32'h99e0_d85f;
        lastPhaseZero = 0;
        lastHbIndex   = 0;
        testsRun      = 0;
        totalChecks   = 0;
        totalErrors   = 0;
        applyReset(resetCycles);
        resetStateTest();
        phaseResetTest();
        syncDetectTest();
        heartbeatWindowTest();
        watchdogTimeoutTest();
        midRunResetTest();
        $display("Summary: %0d tests, %0d checks, %0d errors", testsRun, totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        while (cycleCount < timeoutCycles) begin
            @(negedge evrClk);
        end
        $display("Timeout: tests still running after %0d cycles", timeoutCycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
